// ==== scalar_unit.f ====
hdl/scalar_isa_pkg.sv
hdl/scalar_core_pkg.sv
hdl/scalar_sequencer.sv
hdl/program_counter.sv
hdl/register_file.sv
hdl/scalar_alu.sv
hdl/condition_register.sv
hdl/scalar_unit.sv
verification/scalar_unit_properties.sv
verification/scalar_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the scalar_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module scalar_unit_tb --Mdir "$BUILD_DIR" -f scalar_unit.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vscalar_unit_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
exit 0

// ==== verification/scalar_unit_tb.sv ====
`timescale 1ns/1ps

module scalar_unit_tb;

	import scalar_isa_pkg::*;
	import scalar_core_pkg::*;

	localparam int DATA_WIDTH = 16;
	localparam int ADDR_WIDTH = 8;
	localparam time PERIOD = 40ns;
	localparam int RESET_CYCLES = 8;
	// Executed instructions and program runs over all tests
	localparam int TOTAL_INSTR = 81;
	localparam int TOTAL_RUNS = 17;
	localparam int LIMIT_CYCLES = TOTAL_INSTR * 3 + TOTAL_RUNS * (RESET_CYCLES + 16) + 50;

	logic                    clock = 1'b0;
	logic                    reset;
	logic                    enable;
	logic                    instr_read;
	logic [ADDR_WIDTH-1:0]   instr_address;
	logic [INSTR_WIDTH-1:0]  instr;
	logic [DATA_WIDTH-1:0]   scalar_in;
	logic [DATA_WIDTH-1:0]   scalar_out;
	status_t                 status;
	logic                    term;

	logic [INSTR_WIDTH-1:0]  mem [2**ADDR_WIDTH];
	logic [ADDR_WIDTH-1:0]   fetch_log [$];
	logic [ADDR_WIDTH-1:0]   fetch_addr;
	logic                    fetch_pending = 1'b0;
	logic                    exact_spacing = 1'b0;
	logic [31:0]             seed = 32'h0fc25ba2;
	int                      cycle = 0;
	int                      last_fetch_cycle = 0;
	int                      load_addr = 0;
	int                      tests = 0;
	int                      checks = 0;
	int                      errors = 0;
	int                      test_errors = 0;
	opcode_t                 alu_ops [8] = '{OP_ADD, OP_SUB, OP_AND, OP_OR,
		OP_XOR, OP_SHL, OP_SHR, OP_ADDI};
	int                      expected_pcs [12] = '{0, 1, 2, 4, 5, 6, 8, 9, 11, 13, 14, 16};

	always #(PERIOD / 2) clock = ~clock;

	scalar_unit #(
		.DATA_WIDTH    (DATA_WIDTH),
		.ADDR_WIDTH    (ADDR_WIDTH)
	) scalar_unit_inst (
		.clock         (clock),
		.reset         (reset),
		.enable        (enable),
		.instr_read    (instr_read),
		.instr_address (instr_address),
		.instr         (instr),
		.scalar_in     (scalar_in),
		.scalar_out    (scalar_out),
		.status        (status),
		.term          (term)
	);

	////////////////////////////////////////////////////////////////////////////
	// Instruction memory, word returned one cycle after instr_read
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (instr_read) begin
			fetch_log.push_back(instr_address);
			if (exact_spacing && fetch_log.size() > 1) begin
				check_value("fetch spacing", 32'd3, cycle - last_fetch_cycle);
			end
			last_fetch_cycle = cycle;
			fetch_addr = instr_address;
			fetch_pending = 1'b1;
		end
	end

	always @(negedge clock) begin
		if (fetch_pending) begin
			instr = mem[fetch_addr];
			fetch_pending = 1'b0;
		end
	end

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [INSTR_WIDTH-1:0] encode(opcode_t op, int dst, int src1,
			int src2, int imm);
		return {op, REG_SEL_WIDTH'(dst), REG_SEL_WIDTH'(src1), REG_SEL_WIDTH'(src2),
			IMM_WIDTH'(imm)};
	endfunction

	// Carry in the top bit, result below it
	function automatic logic [DATA_WIDTH:0] expected_alu(opcode_t op,
			logic [DATA_WIDTH-1:0] a, logic [DATA_WIDTH-1:0] b, logic [IMM_WIDTH-1:0] imm);
		logic [DATA_WIDTH-1:0] sext;
		sext = {{(DATA_WIDTH - IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};
		case (op)
			OP_ADD:  return (DATA_WIDTH+1)'(a) + (DATA_WIDTH+1)'(b);
			OP_SUB:  return {a >= b, DATA_WIDTH'(a - b)};
			OP_AND:  return {1'b0, a & b};
			OP_OR:   return {1'b0, a | b};
			OP_XOR:  return {1'b0, a ^ b};
			OP_SHL:  return {1'b0, a << b[3:0]};
			OP_SHR:  return {1'b0, a >> b[3:0]};
			OP_ADDI: return (DATA_WIDTH+1)'(a) + (DATA_WIDTH+1)'(sext);
			default: return '0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("FAIL %s: expected %h, got %h", name, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %s finished with %0d errors", name, test_errors);
		test_errors = 0;
	endtask

	// Unused words decode as END carrying their own address
	task automatic start_program();
		for (int i = 0; i < 2 ** ADDR_WIDTH; i++) begin
			mem[i] = encode(OP_END, 0, 0, 0, i);
		end
		load_addr = 0;
	endtask

	task automatic emit(input logic [INSTR_WIDTH-1:0] word);
		mem[load_addr] = word;
		load_addr++;
	endtask

	task automatic apply_reset();
		enable = 1'b0;
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
		fetch_log.delete();
		@(negedge clock);
	endtask

	// Run to the term pulse, then watch for stray activity
	task automatic finish_program(input int tail);
		enable = 1'b1;
		while (term !== 1'b1) @(negedge clock);
		repeat (tail) begin
			@(negedge clock);
			check_value("term", 32'd0, term);
			check_value("instr_read", 32'd0, instr_read);
		end
	endtask

	task automatic run_program(input int tail);
		apply_reset();
		finish_program(tail);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [DATA_WIDTH-1:0] a;
		logic [DATA_WIDTH-1:0] b;
		logic [DATA_WIDTH-1:0] diff;
		logic [IMM_WIDTH-1:0]  imm;
		logic [DATA_WIDTH:0]   expected;
		logic [2:0]            exp_status;
		logic [2:0]            mask;
		logic [ADDR_WIDTH-1:0] held_address;
		logic [DATA_WIDTH-1:0] held_out;
		reset = 1'b1;
		enable = 1'b0;
		instr = '0;
		scalar_in = '0;

		start_program();
		emit(encode(OP_NOP, 0, 0, 0, 0));
		emit(encode(OP_END, 0, 0, 0, 0));
		apply_reset();
		check_value("term", 32'd0, term);
		check_value("instr_read", 32'd0, instr_read);
		check_value("status", 32'd0, status);
		check_value("instr_address", 32'd0, instr_address);
		finish_program(4);
		check_value("first fetch address", 32'd0, fetch_log[0]);
		end_test("reset");

		foreach (alu_ops[i]) begin
			a = DATA_WIDTH'(next_random() >> (32 - IMM_WIDTH));
			b = DATA_WIDTH'(next_random() >> (32 - IMM_WIDTH));
			imm = IMM_WIDTH'(next_random() >> (32 - IMM_WIDTH));
			start_program();
			emit(encode(OP_LDI, 1, 0, 0, a));
			emit(encode(OP_LDI, 2, 0, 0, b));
			emit(encode(alu_ops[i], 3, 1, 2, imm));
			emit(encode(OP_MOVO, 0, 3, 0, 0));
			emit(encode(OP_END, 0, 0, 0, 0));
			run_program(4);
			expected = expected_alu(alu_ops[i], a, b, imm);
			exp_status = {expected[DATA_WIDTH-1:0] == '0, expected[DATA_WIDTH-1],
				expected[DATA_WIDTH]};
			// Carry is only defined for add and subtract
			mask = (alu_ops[i] == OP_ADD || alu_ops[i] == OP_SUB) ? 3'b111 : 3'b110;
			check_value("scalar_out", expected[DATA_WIDTH-1:0], scalar_out);
			check_value("status", exp_status & mask, status & mask);
		end
		scalar_in = DATA_WIDTH'(next_random());
		start_program();
		emit(encode(OP_MOVS, 4, 0, 0, 0));
		emit(encode(OP_MOVO, 0, 4, 0, 0));
		emit(encode(OP_END, 0, 0, 0, 0));
		run_program(4);
		check_value("scalar_out", scalar_in, scalar_out);
		end_test("alu");

		for (int i = 0; i < 4; i++) begin
			a = DATA_WIDTH'(next_random() >> (32 - IMM_WIDTH));
			b = (i == 0) ? a : DATA_WIDTH'(next_random() >> (32 - IMM_WIDTH));
			diff = a - b;
			start_program();
			emit(encode(OP_LDI, 1, 0, 0, a));
			emit(encode(OP_LDI, 2, 0, 0, b));
			emit(encode(OP_CMP, 0, 1, 2, 0));
			emit(encode(OP_END, 0, 0, 0, 0));
			run_program(4);
			check_value("status", {a == b, diff[DATA_WIDTH-1], a >= b}, status);
		end
		end_test("flags");

		start_program();
		emit(encode(OP_LDI, 1, 0, 0, 5));
		emit(encode(OP_CMP, 0, 1, 1, 0));
		emit(encode(OP_BR, COND_EQ, 0, 0, 4));
		emit(encode(OP_END, 0, 0, 0, 0));
		emit(encode(OP_BR, COND_NE, 0, 0, 3));
		emit(encode(OP_BR, COND_LT, 0, 0, 3));
		emit(encode(OP_BR, COND_ALWAYS, 0, 0, 8));
		emit(encode(OP_END, 0, 0, 0, 0));
		// 0 - 5 leaves zero clear and negative set
		emit(encode(OP_CMP, 0, 0, 1, 0));
		emit(encode(OP_BR, COND_LT, 0, 0, 11));
		emit(encode(OP_END, 0, 0, 0, 0));
		emit(encode(OP_BR, COND_NE, 0, 0, 13));
		emit(encode(OP_END, 0, 0, 0, 0));
		emit(encode(OP_BR, COND_EQ, 0, 0, 12));
		emit(encode(OP_JMP, 0, 0, 0, 16));
		emit(encode(OP_END, 0, 0, 0, 0));
		emit(encode(OP_END, 0, 0, 0, 0));
		exact_spacing = 1'b1;
		run_program(4);
		exact_spacing = 1'b0;
		check_value("fetch count", $size(expected_pcs), fetch_log.size());
		foreach (expected_pcs[i]) begin
			check_value("instr_address", expected_pcs[i], fetch_log[i]);
		end
		end_test("control");

		a = DATA_WIDTH'(next_random() >> (32 - IMM_WIDTH));
		b = DATA_WIDTH'(next_random() >> (32 - IMM_WIDTH));
		start_program();
		emit(encode(OP_LDI, 1, 0, 0, a));
		emit(encode(OP_LDI, 2, 0, 0, b));
		emit(encode(OP_XOR, 3, 1, 2, 0));
		emit(encode(OP_MOVO, 0, 3, 0, 0));
		emit(encode(OP_END, 0, 0, 0, 0));
		apply_reset();
		enable = 1'b1;
		// Freeze with OP_MOVO in EXECUTE
		while (fetch_log.size() < 4) @(negedge clock);
		@(negedge clock);
		enable = 1'b0;
		held_address = instr_address;
		held_out = scalar_out;
		repeat (6) begin
			@(negedge clock);
			check_value("instr_read", 32'd0, instr_read);
			check_value("instr_address", held_address, instr_address);
			check_value("scalar_out", held_out, scalar_out);
		end
		finish_program(4);
		check_value("scalar_out", a ^ b, scalar_out);
		end_test("enable");

		start_program();
		emit(encode(OP_NOP, 0, 0, 0, 0));
		emit(encode(OP_NOP, 0, 0, 0, 0));
		emit(encode(OP_END, 0, 0, 0, 0));
		run_program(12);
		check_value("fetch count", 32'd3, fetch_log.size());
		end_test("term");

		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		#(LIMIT_CYCLES * PERIOD);
		$display("Watchdog: the run did not finish within %0d cycles", LIMIT_CYCLES);
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== verification/scalar_unit_properties.sv ====
`timescale 1ns/1ps

module scalar_unit_properties (
	input logic clock,
	input logic reset,
	input logic enable,
	input logic instr_read,
	input logic term
);

	// Set by the term pulse, cleared only by reset
	logic halted;

	always_ff @(posedge clock) begin
		if (reset) begin
			halted <= 1'b0;
		end else if (term) begin
			halted <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Fetch and termination timing
	////////////////////////////////////////////////////////////////////////////

	term_one_cycle: assert property (@(posedge clock) disable iff (reset)
		term |=> !term)
		else $error("term stayed high for more than one cycle");

	read_needs_enable: assert property (@(posedge clock) disable iff (reset)
		!enable |-> !instr_read)
		else $error("instr_read asserted while enable is low");

	// Three states per instruction
	read_spacing: assert property (@(posedge clock) disable iff (reset)
		instr_read |=> !instr_read ##1 !instr_read)
		else $error("instr_read strobes closer than three cycles");

	no_read_after_term: assert property (@(posedge clock) disable iff (reset)
		(term || halted) |-> !instr_read)
		else $error("instr_read after term");

endmodule

bind scalar_unit scalar_unit_properties scalar_unit_properties_inst (
	.clock      (clock),
	.reset      (reset),
	.enable     (enable),
	.instr_read (instr_read),
	.term       (term)
);

// ==== hdl/scalar_unit.sv ====
`timescale 1ns/1ps

module scalar_unit #(
	parameter int DATA_WIDTH = 16,
	parameter int ADDR_WIDTH = 8
) (
	input  logic                                   clock,
	input  logic                                   reset,
	input  logic                                   enable,
	output logic                                   instr_read,
	output logic [ADDR_WIDTH-1:0]                  instr_address,
	input  logic [scalar_isa_pkg::INSTR_WIDTH-1:0] instr,
	input  logic [DATA_WIDTH-1:0]                  scalar_in,
	output logic [DATA_WIDTH-1:0]                  scalar_out,
	output scalar_core_pkg::status_t               status,
	output logic                                   term
);

	import scalar_isa_pkg::*;
	import scalar_core_pkg::*;

	// Decoded instruction
	opcode_t                  opcode;
	cond_t                    cond;
	logic [REG_SEL_WIDTH-1:0] dst_sel;
	logic [REG_SEL_WIDTH-1:0] src1_sel;
	logic [REG_SEL_WIDTH-1:0] src2_sel;
	logic [IMM_WIDTH-1:0]     immediate;
	logic [ADDR_WIDTH-1:0]    target;

	// Strobes
	logic reg_we;
	logic out_we;
	logic flags_we;
	logic pc_advance;
	logic pc_load;
	logic branch_taken;

	// Datapath
	logic [DATA_WIDTH-1:0] src1_data;
	logic [DATA_WIDTH-1:0] src2_data;
	logic [DATA_WIDTH-1:0] alu_result;
	status_t               alu_flags;

	////////////////////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////////////////////

	scalar_sequencer #(
		.ADDR_WIDTH   (ADDR_WIDTH)
	) scalar_sequencer_inst (
		.clock        (clock),
		.reset        (reset),
		.enable       (enable),
		.instr        (instr),
		.branch_taken (branch_taken),
		.instr_read   (instr_read),
		.term         (term),
		.opcode       (opcode),
		.dst_sel      (dst_sel),
		.src1_sel     (src1_sel),
		.src2_sel     (src2_sel),
		.immediate    (immediate),
		.cond         (cond),
		.target       (target),
		.reg_we       (reg_we),
		.out_we       (out_we),
		.flags_we     (flags_we),
		.pc_advance   (pc_advance),
		.pc_load      (pc_load)
	);

	program_counter #(
		.ADDR_WIDTH    (ADDR_WIDTH)
	) program_counter_inst (
		.clock         (clock),
		.reset         (reset),
		.enable        (enable),
		.pc_advance    (pc_advance),
		.pc_load       (pc_load),
		.target        (target),
		.instr_address (instr_address)
	);

	////////////////////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////////////////////

	register_file #(
		.DATA_WIDTH (DATA_WIDTH)
	) register_file_inst (
		.clock      (clock),
		.reset      (reset),
		.enable     (enable),
		.src1_sel   (src1_sel),
		.src2_sel   (src2_sel),
		.dst_sel    (dst_sel),
		.reg_we     (reg_we),
		.out_we     (out_we),
		.write_data (alu_result),
		.src1_data  (src1_data),
		.src2_data  (src2_data),
		.scalar_out (scalar_out)
	);

	scalar_alu #(
		.DATA_WIDTH (DATA_WIDTH)
	) scalar_alu_inst (
		.opcode     (opcode),
		.src1_data  (src1_data),
		.src2_data  (src2_data),
		.immediate  (immediate),
		.scalar_in  (scalar_in),
		.result     (alu_result),
		.flags      (alu_flags)
	);

	condition_register #(
		.DATA_WIDTH   (DATA_WIDTH)
	) condition_register_inst (
		.clock        (clock),
		.reset        (reset),
		.enable       (enable),
		.flags_we     (flags_we),
		.flags        (alu_flags),
		.cond         (cond),
		.status       (status),
		.branch_taken (branch_taken)
	);

endmodule

// ==== hdl/condition_register.sv ====
`timescale 1ns/1ps

module condition_register #(
	parameter int DATA_WIDTH = 16
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      enable,
	input  logic                      flags_we,
	input  scalar_core_pkg::status_t  flags,
	input  scalar_isa_pkg::cond_t     cond,
	output scalar_core_pkg::status_t  status,
	output logic                      branch_taken
);

	import scalar_isa_pkg::*;

	always_ff @(posedge clock) begin
		if (reset) begin
			status <= '0;
		end else if (enable && flags_we) begin
			status <= flags;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Branch condition against stored flags
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (cond)
			COND_ALWAYS: branch_taken = 1'b1;
			COND_EQ:     branch_taken = status.zero;
			COND_NE:     branch_taken = !status.zero;
			COND_LT:     branch_taken = status.negative;
			default:     branch_taken = 1'b0;
		endcase
	end

endmodule

// ==== hdl/scalar_alu.sv ====
`timescale 1ns/1ps

module scalar_alu #(
	parameter int DATA_WIDTH = 16
) (
	input  scalar_isa_pkg::opcode_t                 opcode,
	input  logic [DATA_WIDTH-1:0]                   src1_data,
	input  logic [DATA_WIDTH-1:0]                   src2_data,
	input  logic [scalar_isa_pkg::IMM_WIDTH-1:0]    immediate,
	input  logic [DATA_WIDTH-1:0]                   scalar_in,
	output logic [DATA_WIDTH-1:0]                   result,
	output scalar_core_pkg::status_t                flags
);

	import scalar_isa_pkg::*;

	// Shift distance taken from the low bits of src2
	localparam int SHIFT_BITS = 4;

	logic [DATA_WIDTH-1:0] imm_sext;
	logic [DATA_WIDTH-1:0] imm_zext;
	logic [SHIFT_BITS-1:0] shamt;
	logic [DATA_WIDTH:0]   wide;

	assign imm_sext = DATA_WIDTH'(signed'(immediate));
	assign imm_zext = DATA_WIDTH'(immediate);
	assign shamt    = src2_data[SHIFT_BITS-1:0];

	////////////////////////////////////////////////////////////////////////////
	// Result with carry in the extra top bit
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (opcode)
			OP_ADD:  wide = {1'b0, src1_data} + {1'b0, src2_data};
			// Carry set means no borrow
			OP_SUB,
			OP_CMP:  wide = {1'b0, src1_data} + {1'b0, ~src2_data} + 1'b1;
			OP_ADDI: wide = {1'b0, src1_data} + {1'b0, imm_sext};
			OP_AND:  wide = {1'b0, src1_data & src2_data};
			OP_OR:   wide = {1'b0, src1_data | src2_data};
			OP_XOR:  wide = {1'b0, src1_data ^ src2_data};
			OP_SHL:  wide = {1'b0, src1_data << shamt};
			OP_SHR:  wide = {1'b0, src1_data >> shamt};
			OP_LDI:  wide = {1'b0, imm_zext};
			OP_MOVS: wide = {1'b0, scalar_in};
			OP_MOVO: wide = {1'b0, src1_data};
			default: wide = '0;
		endcase
	end

	assign result = wide[DATA_WIDTH-1:0];

	// Flags only land in status when the sequencer says so
	assign flags = '{
		zero:     (result == '0),
		negative: result[DATA_WIDTH-1],
		carry:    wide[DATA_WIDTH]
	};

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps

module register_file #(
	parameter int DATA_WIDTH = 16
) (
	input  logic                                     clock,
	input  logic                                     reset,
	input  logic                                     enable,
	input  logic [scalar_isa_pkg::REG_SEL_WIDTH-1:0] src1_sel,
	input  logic [scalar_isa_pkg::REG_SEL_WIDTH-1:0] src2_sel,
	input  logic [scalar_isa_pkg::REG_SEL_WIDTH-1:0] dst_sel,
	input  logic                                     reg_we,
	input  logic                                     out_we,
	input  logic [DATA_WIDTH-1:0]                    write_data,
	output logic [DATA_WIDTH-1:0]                    src1_data,
	output logic [DATA_WIDTH-1:0]                    src2_data,
	output logic [DATA_WIDTH-1:0]                    scalar_out
);

	import scalar_isa_pkg::*;

	localparam int NUM_REGS = 2 ** REG_SEL_WIDTH;

	logic [DATA_WIDTH-1:0] regs [NUM_REGS];

	// General registers, single write port
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (enable && reg_we) begin
			regs[dst_sel] <= write_data;
		end
	end

	// Scalar output register fed from the first read port
	always_ff @(posedge clock) begin
		if (reset) begin
			scalar_out <= '0;
		end else if (enable && out_we) begin
			scalar_out <= src1_data;
		end
	end

	assign src1_data = regs[src1_sel];
	assign src2_data = regs[src2_sel];

endmodule

// ==== hdl/program_counter.sv ====
`timescale 1ns/1ps

module program_counter #(
	parameter int ADDR_WIDTH = 8
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  enable,
	input  logic                  pc_advance,
	input  logic                  pc_load,
	input  logic [ADDR_WIDTH-1:0] target,
	output logic [ADDR_WIDTH-1:0] instr_address
);

	logic [ADDR_WIDTH-1:0] pc;
	logic [ADDR_WIDTH-1:0] next_pc;

	// Jump or branch target wins over the sequential address
	always_comb begin
		if (pc_load) begin
			next_pc = target;
		end else begin
			next_pc = pc + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Address register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
		end else if (enable && pc_advance) begin
			pc <= next_pc;
		end
	end

	// Wraps at 2**ADDR_WIDTH on overflow
	assign instr_address = pc;

endmodule

// ==== hdl/scalar_sequencer.sv ====
`timescale 1ns/1ps

module scalar_sequencer #(
	parameter int ADDR_WIDTH = 8
) (
	input  logic                                        clock,
	input  logic                                        reset,
	input  logic                                        enable,
	input  logic [scalar_isa_pkg::INSTR_WIDTH-1:0]      instr,
	input  logic                                        branch_taken,
	output logic                                        instr_read,
	output logic                                        term,
	output scalar_isa_pkg::opcode_t                     opcode,
	output logic [scalar_isa_pkg::REG_SEL_WIDTH-1:0]    dst_sel,
	output logic [scalar_isa_pkg::REG_SEL_WIDTH-1:0]    src1_sel,
	output logic [scalar_isa_pkg::REG_SEL_WIDTH-1:0]    src2_sel,
	output logic [scalar_isa_pkg::IMM_WIDTH-1:0]        immediate,
	output scalar_isa_pkg::cond_t                       cond,
	output logic [ADDR_WIDTH-1:0]                       target,
	output logic                                        reg_we,
	output logic                                        out_we,
	output logic                                        flags_we,
	output logic                                        pc_advance,
	output logic                                        pc_load
);

	import scalar_isa_pkg::*;
	import scalar_core_pkg::*;

	// Field positions, counted down from the top of the word
	localparam int OP_LSB   = INSTR_WIDTH - OPCODE_WIDTH;
	localparam int DST_LSB  = OP_LSB - REG_SEL_WIDTH;
	localparam int SRC1_LSB = DST_LSB - REG_SEL_WIDTH;
	localparam int SRC2_LSB = SRC1_LSB - REG_SEL_WIDTH;

	seq_state_t             state;
	logic [INSTR_WIDTH-1:0] instr_reg;
	logic                   executing;
	logic                   writes_reg;
	logic                   writes_out;
	logic                   writes_flags;

	////////////////////////////////////////////////////////////////////////////
	// State machine
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_FETCH;
		end else if (enable) begin
			case (state)
				ST_FETCH:   state <= ST_DECODE;
				ST_DECODE:  state <= ST_EXECUTE;
				ST_EXECUTE: state <= (opcode == OP_END) ? ST_HALT : ST_FETCH;
				default:    state <= ST_HALT;
			endcase
		end
	end

	// Memory answers during DECODE
	always_ff @(posedge clock) begin
		if (enable && state == ST_DECODE) begin
			instr_reg <= instr;
		end
	end

	// Single-cycle pulse, not stretched by a low enable
	always_ff @(posedge clock) begin
		if (reset) begin
			term <= 1'b0;
		end else begin
			term <= enable && executing && opcode == OP_END;
		end
	end

	assign instr_read = enable && state == ST_FETCH;
	assign executing  = state == ST_EXECUTE;

	// Instruction fields
	assign opcode    = opcode_t'(instr_reg[INSTR_WIDTH-1:OP_LSB]);
	assign dst_sel   = instr_reg[OP_LSB-1:DST_LSB];
	assign src1_sel  = instr_reg[DST_LSB-1:SRC1_LSB];
	assign src2_sel  = instr_reg[SRC1_LSB-1:SRC2_LSB];
	assign immediate = instr_reg[IMM_WIDTH-1:0];
	assign cond      = cond_t'(instr_reg[DST_LSB+1:DST_LSB]);
	assign target    = immediate[ADDR_WIDTH-1:0];

	////////////////////////////////////////////////////////////////////////////
	// Write strobe decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		writes_reg   = 1'b0;
		writes_out   = 1'b0;
		writes_flags = 1'b0;
		case (opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
			OP_SHL, OP_SHR, OP_ADDI, OP_MOVS: begin
				writes_reg   = 1'b1;
				writes_flags = 1'b1;
			end
			OP_LDI:  writes_reg = 1'b1;
			OP_MOVO: writes_out = 1'b1;
			OP_CMP:  writes_flags = 1'b1;
			default: ;
		endcase
	end

	assign reg_we     = executing && writes_reg;
	assign out_we     = executing && writes_out;
	assign flags_we   = executing && writes_flags;
	assign pc_advance = executing;
	assign pc_load    = executing && (opcode == OP_JMP || (opcode == OP_BR && branch_taken));

endmodule

// ==== hdl/scalar_core_pkg.sv ====
package scalar_core_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sequencer and status definitions
	////////////////////////////////////////////////////////////////////////////

	// One instruction walks FETCH -> DECODE -> EXECUTE
	typedef enum logic [1:0] {
		ST_FETCH,
		ST_DECODE,
		ST_EXECUTE,
		ST_HALT
	} seq_state_t;

	// Status flags written by ALU operations and OP_CMP
	typedef struct packed {
		logic zero;
		logic negative;
		logic carry;
	} status_t;

endpackage

// ==== hdl/scalar_isa_pkg.sv ====
package scalar_isa_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Instruction word layout
	//  [23:20] opcode, [19:17] dst, [16:14] src1, [13:11] src2, [10:0] imm
	////////////////////////////////////////////////////////////////////////////

	localparam int INSTR_WIDTH   = 24;
	localparam int OPCODE_WIDTH  = 4;
	localparam int REG_SEL_WIDTH = 3;
	localparam int IMM_WIDTH     = 11;

	// Operation codes, encoded in listed order from zero
	typedef enum logic [OPCODE_WIDTH-1:0] {
		OP_NOP,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SHL,
		OP_SHR,
		OP_ADDI,
		OP_LDI,
		OP_MOVS,
		OP_MOVO,
		OP_CMP,
		OP_BR,
		OP_JMP,
		OP_END
	} opcode_t;

	// Branch condition, low bits of the dst field of OP_BR
	typedef enum logic [1:0] {
		COND_ALWAYS,
		COND_EQ,
		COND_NE,
		COND_LT
	} cond_t;

endpackage
